//--- Bender.yml
package:
  name: multifmt_slice

sources:
  - fpslice_pkg.sv
  - lane_bus_if.sv
  - noncomp_lane.sv
  - lane_pipeline.sv
  - result_packer.sv
  - multifmt_slice.sv
  - target: test
    files:
      - multifmt_slice_properties.sv
      - tb_multifmt_slice.sv

//--- fpslice_pkg.sv
package fpslice_pkg;

  // -----------------------------------------------
  // Widths
  // -----------------------------------------------
  localparam int unsigned DATA_WIDTH = 64;
  localparam int unsigned FP32_WIDTH = 32;
  localparam int unsigned FP16_WIDTH = 16;
  localparam int unsigned NUM_LANES  = DATA_WIDTH / FP16_WIDTH; // Narrowest format sets the count

  typedef logic [DATA_WIDTH-1:0] data_t;      // Full operand or result
  typedef logic [FP32_WIDTH-1:0] lane_data_t; // One lane slot, FP16 uses the low half

  // -----------------------------------------------
  // Formats and operations
  // -----------------------------------------------
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    MIN,
    MAX,
    SGNJ,
    SGNJN,
    SGNJX
  } operation_e;

  // -----------------------------------------------
  // Side information
  // -----------------------------------------------
  typedef logic [4:0] status_t; // NV, DZ, OF, UF, NX from msb down
  localparam int unsigned STATUS_NV = 4;

  typedef logic [3:0]           tag_t;
  typedef logic [NUM_LANES-1:0] mask_t;

  // Quiet canonical NaNs
  localparam logic [FP32_WIDTH-1:0] CANONICAL_NAN32 = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] CANONICAL_NAN16 = 16'h7E00;

endpackage

//--- lane_bus_if.sv
interface lane_bus_if;

  logic                                                  valid;
  logic                                                  ready;
  fpslice_pkg::lane_data_t [fpslice_pkg::NUM_LANES-1:0] results;
  fpslice_pkg::status_t    [fpslice_pkg::NUM_LANES-1:0] status;  // Per-lane flags
  fpslice_pkg::mask_t                                    mask;
  fpslice_pkg::fp_format_e                               fmt;
  logic                                                  vector;  // Vectorial op
  fpslice_pkg::tag_t                                     tag;

  // Producer side
  modport src (
    output valid, results, status, mask, fmt, vector, tag,
    input  ready
  );

  // Consumer side
  modport dst (
    input  valid, results, status, mask, fmt, vector, tag,
    output ready
  );

endinterface

//--- lane_pipeline.sv
module lane_pipeline #(
  parameter int unsigned NumPipeRegs = 1
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  input  logic    flush_i,
  lane_bus_if.dst in_bus,
  lane_bus_if.src out_bus,
  output logic    busy_o
);

  // All lanes travel together as one flat word
  localparam int unsigned PayloadWidth =
      fpslice_pkg::NUM_LANES * ($bits(fpslice_pkg::lane_data_t) + $bits(fpslice_pkg::status_t))
      + $bits(fpslice_pkg::mask_t) + $bits(fpslice_pkg::fp_format_e) + 1
      + $bits(fpslice_pkg::tag_t);

  // Index i holds the item after i register stages
  logic [0:NumPipeRegs][PayloadWidth-1:0] data_q;
  logic [0:NumPipeRegs]                   valid_q;
  logic [0:NumPipeRegs]                   stage_ready; // Combinational, travels backwards
  logic                                   out_fmt;

  // -----------------------------------------------
  // Input side
  // -----------------------------------------------
  assign data_q[0]    = {in_bus.results, in_bus.status, in_bus.mask, in_bus.fmt,
                         in_bus.vector, in_bus.tag};
  assign valid_q[0]   = in_bus.valid;
  assign in_bus.ready = stage_ready[0];

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    // Advance when next stage takes the item or holds only a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_q[i]) begin
        data_q[i+1] <= data_q[i]; // Load only on a real item
      end
    end
  end

  // -----------------------------------------------
  // Output side
  // -----------------------------------------------
  assign stage_ready[NumPipeRegs] = out_bus.ready;
  assign out_bus.valid            = valid_q[NumPipeRegs];
  assign {out_bus.results, out_bus.status, out_bus.mask, out_fmt,
          out_bus.vector, out_bus.tag} = data_q[NumPipeRegs];
  assign out_bus.fmt              = fpslice_pkg::fp_format_e'(out_fmt);

  always_comb begin : busy
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o |= valid_q[i];
    end
  end

endmodule

//--- multifmt_slice.sv
module multifmt_slice #(
  parameter int unsigned NumPipeRegs = 1
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Operation
  input  fpslice_pkg::data_t [1:0]      operands_i,
  input  fpslice_pkg::operation_e       op_i,
  input  fpslice_pkg::fp_format_e       fmt_i,
  input  logic                          vectorial_op_i,
  input  fpslice_pkg::tag_t             tag_i,
  input  fpslice_pkg::mask_t            simd_mask_i,
  // Input handshake
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          flush_i,
  // Result
  output fpslice_pkg::data_t            result_o,
  output fpslice_pkg::status_t          status_o,
  output fpslice_pkg::tag_t             tag_o,
  // Output handshake
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          busy_o
);

  fpslice_pkg::lane_data_t [fpslice_pkg::NUM_LANES-1:0] lane_result;
  fpslice_pkg::status_t    [fpslice_pkg::NUM_LANES-1:0] lane_status;
  int unsigned                                          fmt_width;

  lane_bus_if lanes_bus ();
  lane_bus_if packed_bus ();

  assign fmt_width = (fmt_i == fpslice_pkg::FP16) ? fpslice_pkg::FP16_WIDTH
                                                   : fpslice_pkg::FP32_WIDTH;

  // -----------------------------------------------
  // Lanes
  // -----------------------------------------------
  for (genvar lane = 0; lane < int'(fpslice_pkg::NUM_LANES); lane++) begin : gen_lanes
    localparam int unsigned LaneWidth = (lane < 2) ? fpslice_pkg::FP32_WIDTH
                                                   : fpslice_pkg::FP16_WIDTH;

    fpslice_pkg::lane_data_t lane_a, lane_b;

    // Upper bits beyond the format are ignored in the lane
    assign lane_a = fpslice_pkg::lane_data_t'(operands_i[0] >> (lane * fmt_width));
    assign lane_b = fpslice_pkg::lane_data_t'(operands_i[1] >> (lane * fmt_width));

    noncomp_lane #(
      .LaneWidth ( LaneWidth )
    ) i_noncomp_lane (
      .a_i      ( lane_a            ),
      .b_i      ( lane_b            ),
      .op_i     ( op_i              ),
      .fmt_i    ( fmt_i             ),
      .result_o ( lane_result[lane] ),
      .status_o ( lane_status[lane] )
    );
  end

  // Lane outputs plus side info enter the pipeline
  assign lanes_bus.valid   = in_valid_i;
  assign lanes_bus.results = lane_result;
  assign lanes_bus.status  = lane_status;
  assign lanes_bus.mask    = simd_mask_i;
  assign lanes_bus.fmt     = fmt_i;
  assign lanes_bus.vector  = vectorial_op_i;
  assign lanes_bus.tag     = tag_i;
  assign in_ready_o        = lanes_bus.ready;

  // -----------------------------------------------
  // Pipeline and output packing
  // -----------------------------------------------
  lane_pipeline #(
    .NumPipeRegs ( NumPipeRegs )
  ) i_lane_pipeline (
    .clk_i   ( clk_i      ),
    .rst_n_i ( rst_n_i    ),
    .flush_i ( flush_i    ),
    .in_bus  ( lanes_bus  ),
    .out_bus ( packed_bus ),
    .busy_o  ( busy_o     )
  );

  result_packer i_result_packer (
    .in_bus      ( packed_bus  ),
    .out_ready_i ( out_ready_i ),
    .result_o    ( result_o    ),
    .status_o    ( status_o    ),
    .tag_o       ( tag_o       ),
    .out_valid_o ( out_valid_o )
  );

endmodule

//--- multifmt_slice_properties.sv
module multifmt_slice_properties (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               flush_i,
  input logic               in_ready_o,
  input logic               out_valid_o,
  input logic               out_ready_i,
  input logic               busy_o,
  input fpslice_pkg::data_t result_o
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned failures = 0; // Failed assertions so far

  // --------------------------------------------------
  // Output handshake
  // --------------------------------------------------
  // A stalled result stays put until taken
  stall_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_o && !out_ready_i && !flush_i) |=> (out_valid_o && $stable(result_o)))
    else begin
      failures++;
      $error("Output changed while stalled");
    end

  // Empty and ready right after reset release
  reset_state: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> (!out_valid_o && !busy_o && in_ready_o))
    else begin
      failures++;
      $error("Wrong handshake state after reset release");
    end

  flush_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    flush_i |=> !out_valid_o)
    else begin
      failures++;
      $error("Output still valid after flush");
    end

endmodule

//--- noncomp_lane.sv
module noncomp_lane #(
  parameter int unsigned LaneWidth = 32
) (
  input  fpslice_pkg::lane_data_t a_i,
  input  fpslice_pkg::lane_data_t b_i,
  input  fpslice_pkg::operation_e op_i,
  input  fpslice_pkg::fp_format_e fmt_i,
  output fpslice_pkg::lane_data_t result_o,
  output fpslice_pkg::status_t    status_o
);

  // Narrow lanes only ever carry FP16
  localparam bit HasFp32 = (LaneWidth == fpslice_pkg::FP32_WIDTH);

  fpslice_pkg::lane_data_t a_val, b_val; // Operands with unused upper bits cleared
  fpslice_pkg::lane_data_t can_nan;
  fpslice_pkg::lane_data_t sgnj_res;
  fpslice_pkg::lane_data_t res;
  logic [30:0]             mag_a, mag_b;
  logic                    sign_a, sign_b;
  logic                    nan_a, nan_b;
  logic                    quiet_a, quiet_b;
  logic                    inj_sign;
  logic                    a_lt_b;
  logic                    nv;
  logic                    fmt_ok;

  assign fmt_ok = HasFp32 || (fmt_i == fpslice_pkg::FP16);

  // -----------------------------------------------
  // Classification
  // -----------------------------------------------
  always_comb begin : decode
    if (fmt_i == fpslice_pkg::FP16) begin
      a_val   = {16'h0000, a_i[15:0]};
      b_val   = {16'h0000, b_i[15:0]};
      sign_a  = a_i[15];
      sign_b  = b_i[15];
      mag_a   = {16'h0000, a_i[14:0]};
      mag_b   = {16'h0000, b_i[14:0]};
      nan_a   = (&a_i[14:10]) & (|a_i[9:0]); // Exponent all ones, mantissa nonzero
      nan_b   = (&b_i[14:10]) & (|b_i[9:0]);
      quiet_a = a_i[9];
      quiet_b = b_i[9];
      can_nan = {16'h0000, fpslice_pkg::CANONICAL_NAN16};
    end else begin
      a_val   = a_i;
      b_val   = b_i;
      sign_a  = a_i[31];
      sign_b  = b_i[31];
      mag_a   = a_i[30:0];
      mag_b   = b_i[30:0];
      nan_a   = (&a_i[30:23]) & (|a_i[22:0]);
      nan_b   = (&b_i[30:23]) & (|b_i[22:0]);
      quiet_a = a_i[22];
      quiet_b = b_i[22];
      can_nan = fpslice_pkg::CANONICAL_NAN32;
    end
  end

  // Sign-magnitude order, so -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a
                : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

  // -----------------------------------------------
  // Sign injection
  // -----------------------------------------------
  always_comb begin : inject
    case (op_i)
      fpslice_pkg::SGNJN: inj_sign = ~sign_b;
      fpslice_pkg::SGNJX: inj_sign = sign_a ^ sign_b;
      default:            inj_sign = sign_b;
    endcase
  end

  assign sgnj_res = (fmt_i == fpslice_pkg::FP16) ? {16'h0000, inj_sign, a_i[14:0]}
                                                  : {inj_sign, a_i[30:0]};

  always_comb begin : compute
    res = '0;
    nv  = 1'b0;
    case (op_i)
      fpslice_pkg::MIN, fpslice_pkg::MAX: begin
        nv = (nan_a & ~quiet_a) | (nan_b & ~quiet_b); // Signaling input
        if (nan_a && nan_b) begin
          res = can_nan;
        end else if (nan_a) begin
          res = b_val;
        end else if (nan_b) begin
          res = a_val;
        end else if ((op_i == fpslice_pkg::MIN) == a_lt_b) begin
          res = a_val; // A is the min for MIN, not below B for MAX
        end else begin
          res = b_val;
        end
      end
      fpslice_pkg::SGNJ, fpslice_pkg::SGNJN, fpslice_pkg::SGNJX: res = sgnj_res;
      default: res = '0;
    endcase
  end

  always_comb begin : outputs
    result_o                        = fmt_ok ? res : '0;
    status_o                        = '0;
    status_o[fpslice_pkg::STATUS_NV] = nv & fmt_ok;
  end

endmodule

//--- result_packer.sv
module result_packer (
  lane_bus_if.dst                 in_bus,
  input  logic                    out_ready_i,
  output fpslice_pkg::data_t      result_o,
  output fpslice_pkg::status_t    status_o,
  output fpslice_pkg::tag_t       tag_o,
  output logic                    out_valid_o
);

  localparam int unsigned NumFp32Lanes = fpslice_pkg::DATA_WIDTH / fpslice_pkg::FP32_WIDTH;

  fpslice_pkg::mask_t lane_used;

  assign in_bus.ready = out_ready_i; // Packing adds no storage
  assign out_valid_o  = in_bus.valid;
  assign tag_o        = in_bus.tag;

  // Scalar ops use lane 0 only
  always_comb begin : used_lanes
    lane_used = fpslice_pkg::mask_t'(1);
    if (in_bus.vector) begin
      lane_used = (in_bus.fmt == fpslice_pkg::FP16) ? '1
                                                     : fpslice_pkg::mask_t'((1 << NumFp32Lanes) - 1);
    end
  end

  // -----------------------------------------------
  // Packing and status collapse
  // -----------------------------------------------
  always_comb begin : pack
    fpslice_pkg::status_t flags;
    flags    = '0;
    result_o = '1; // NaN-box everything not written below
    for (int l = 0; l < int'(fpslice_pkg::NUM_LANES); l++) begin
      if (lane_used[l]) begin
        if (in_bus.fmt == fpslice_pkg::FP16) begin
          result_o[l*fpslice_pkg::FP16_WIDTH +: fpslice_pkg::FP16_WIDTH] =
              in_bus.results[l][fpslice_pkg::FP16_WIDTH-1:0];
        end else if (l < int'(NumFp32Lanes)) begin
          result_o[l*fpslice_pkg::FP32_WIDTH +: fpslice_pkg::FP32_WIDTH] = in_bus.results[l];
        end
        if (in_bus.mask[l]) begin
          flags |= in_bus.status[l]; // Masked lanes raise nothing
        end
      end
    end
    status_o = flags;
  end

endmodule

//--- src.f
fpslice_pkg.sv
lane_bus_if.sv
noncomp_lane.sv
lane_pipeline.sv
result_packer.sv
multifmt_slice.sv
multifmt_slice_properties.sv
tb_multifmt_slice.sv

//--- tb_multifmt_slice.sv
module tb_multifmt_slice;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned PIPE_REGS    = 2;
  localparam int unsigned FREE_OPS     = 120; // out_ready held high, latency checked
  localparam int unsigned STALL_OPS    = 240;
  localparam int unsigned FLUSH_ROUNDS = 6;
  localparam int unsigned FLUSH_OPS    = 8;
  localparam int unsigned NUM_OPS      = FREE_OPS + STALL_OPS + FLUSH_ROUNDS * FLUSH_OPS;
  localparam int unsigned CYCLE_LIMIT  = 20 * NUM_OPS + 100;

  typedef struct packed {
    fpslice_pkg::data_t   result;
    fpslice_pkg::status_t status;
    fpslice_pkg::tag_t    tag;
    int unsigned          acc_cycle;
    bit                   timed;
  } exp_item_t;

  logic                          clk_i = 1'b0;
  logic                          rst_n_i;
  fpslice_pkg::data_t [1:0]      operands_i;
  fpslice_pkg::operation_e       op_i;
  fpslice_pkg::fp_format_e       fmt_i;
  logic                          vectorial_op_i;
  fpslice_pkg::tag_t             tag_i;
  fpslice_pkg::mask_t            simd_mask_i;
  logic                          in_valid_i, in_ready_o, flush_i;
  fpslice_pkg::data_t            result_o;
  fpslice_pkg::status_t          status_o;
  fpslice_pkg::tag_t             tag_o;
  logic                          out_valid_o, out_ready_i, busy_o;

  int                            seed;
  int unsigned                   cycles = 0;
  int unsigned                   checks = 0;
  int unsigned                   errors = 0;
  bit                            took_input = 1'b0; // Set by the monitor on acceptance
  bit                            timed_phase = 1'b0;
  fpslice_pkg::tag_t             next_tag = '0;
  exp_item_t                     expq[$];

  always #5 clk_i = ~clk_i;

  multifmt_slice #(
    .NumPipeRegs ( PIPE_REGS )
  ) DUT (
    .clk_i, .rst_n_i, .operands_i, .op_i, .fmt_i, .vectorial_op_i, .tag_i, .simd_mask_i,
    .in_valid_i, .in_ready_o, .flush_i, .result_o, .status_o, .tag_o,
    .out_valid_o, .out_ready_i, .busy_o
  );

  bind multifmt_slice multifmt_slice_properties i_properties (.*);

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Returns {nv, result} for one element, FP16 values sit in the low half
  function automatic logic [32:0] element_ref(input logic [31:0] a_in, input logic [31:0] b_in,
                                             input fpslice_pkg::operation_e op, input bit half);
    logic [31:0] sign, expo, quiet, full, can, a, b, ka, kb;
    logic        sa, sb, nan_a, nan_b, snan;
    sign  = half ? 32'h0000_8000 : 32'h8000_0000;
    expo  = half ? 32'h0000_7C00 : 32'h7F80_0000;
    quiet = half ? 32'h0000_0200 : 32'h0040_0000;
    full  = (sign << 1) - 32'd1;
    can   = half ? {16'h0000, fpslice_pkg::CANONICAL_NAN16} : fpslice_pkg::CANONICAL_NAN32;
    a     = a_in & full;
    b     = b_in & full;
    sa    = |(a & sign);
    sb    = |(b & sign);
    nan_a = ((a & expo) == expo) && ((a & ~sign & ~expo) != 0);
    nan_b = ((b & expo) == expo) && ((b & ~sign & ~expo) != 0);
    snan  = (nan_a && ((a & quiet) == 0)) || (nan_b && ((b & quiet) == 0));
    ka    = sa ? (~a & full) : (a | sign); // Monotonic key, -0 below +0
    kb    = sb ? (~b & full) : (b | sign);
    case (op)
      fpslice_pkg::SGNJ:  return {1'b0, (a & ~sign) | (sb ? sign : 32'h0)};
      fpslice_pkg::SGNJN: return {1'b0, (a & ~sign) | (sb ? 32'h0 : sign)};
      fpslice_pkg::SGNJX: return {1'b0, (a & ~sign) | ((sa ^ sb) ? sign : 32'h0)};
      default: begin
        if (nan_a && nan_b) return {snan, can};
        if (nan_a) return {snan, b};
        if (nan_b) return {snan, a};
        if (op == fpslice_pkg::MIN) return {snan, (ka < kb) ? a : b};
        return {snan, (ka > kb) ? a : b};
      end
    endcase
  endfunction

  task automatic predict(input fpslice_pkg::data_t a, input fpslice_pkg::data_t b,
                         input fpslice_pkg::operation_e op, input bit half, input bit vec,
                         input fpslice_pkg::mask_t mask, output fpslice_pkg::data_t res,
                         output fpslice_pkg::status_t st);
    int unsigned w, n;
    logic [32:0] r;
    w   = half ? 16 : 32;
    n   = !vec ? 1 : (half ? 4 : 2);
    res = '1;                           // Boxing of unused fields
    st  = '0;
    for (int unsigned l = 0; l < n; l++) begin
      r = element_ref(32'(a >> (l * w)), 32'(b >> (l * w)), op, half);
      if (half) res[l*16 +: 16] = r[15:0];
      else      res[l*32 +: 32] = r[31:0];
      if (mask[l] && r[32]) st[fpslice_pkg::STATUS_NV] = 1'b1;
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  function automatic logic [31:0] pick_element(input bit half);
    logic [31:0] r;
    logic [31:0] sgn;
    r   = $random(seed);
    sgn = half ? {16'h0000, r[31], 15'h0000} : {r[31], 31'h0};
    case (r[30:28])
      3'd0:    return sgn;                                      // Signed zero
      3'd1:    return half ? (sgn | 32'h7E00 | r[8:0]) : (sgn | 32'h7FC0_0000 | r[21:0]);
      3'd2:    return half ? (sgn | 32'h7C01 | r[8:0]) : (sgn | 32'h7F80_0001 | r[21:0]);
      3'd3:    return half ? (sgn | 32'h7C00) : (sgn | 32'h7F80_0000); // Infinity
      default: return half ? {16'h0000, r[15:0]} : r;
    endcase
  endfunction

  function automatic fpslice_pkg::data_t make_operand(input bit half);
    fpslice_pkg::data_t v;
    logic [31:0]        e;
    v = '0;
    for (int i = 0; i < 4; i++) begin
      e = pick_element(half);
      if (half) v[i*16 +: 16] = e[15:0];
      else if (i < 2) v[i*32 +: 32] = e;
    end
    return v;
  endfunction

  task automatic drive_operation();
    logic [31:0] r;
    r              = $random(seed);
    fmt_i          = r[0] ? fpslice_pkg::FP16 : fpslice_pkg::FP32;
    vectorial_op_i = r[1];
    simd_mask_i    = r[5:2];
    op_i           = fpslice_pkg::operation_e'(r[10:8] % 3'd5);
    tag_i          = next_tag;
    next_tag       = next_tag + 1'b1; // Sequential tags expose reordering
    operands_i[0]  = make_operand(r[0]);
    operands_i[1]  = make_operand(r[0]);
  endtask

  task automatic run_ops(input int unsigned n, input bit stall);
    int unsigned sent;
    sent        = 0;
    timed_phase = !stall;
    while (sent < n) begin
      @(negedge clk_i);
      if (took_input) sent++;
      if (sent == n) begin
        in_valid_i = 1'b0;
      end else if (!in_valid_i || took_input) begin
        in_valid_i = ($random(seed) & 3) != 0;
        if (in_valid_i) drive_operation();
      end
      out_ready_i = stall ? (($random(seed) & 3) != 0) : 1'b1;
    end
  endtask

  task automatic drain();
    while (expq.size() != 0) begin
      @(negedge clk_i);
      out_ready_i = 1'b1;
    end
    @(negedge clk_i);
    check_value("busy after drain", 64'(busy_o), 64'd0);
  endtask

  task automatic pulse_flush();
    @(negedge clk_i);
    out_ready_i = 1'b0;
    flush_i     = 1'b1;
    @(negedge clk_i);
    flush_i     = 1'b0;
    check_value("busy after flush", 64'(busy_o), 64'd0);
  endtask

  // Monitor, scoreboard and cycle limit share one process
  always @(posedge clk_i) begin
    exp_item_t            item;
    fpslice_pkg::data_t   res;
    fpslice_pkg::status_t st;
    cycles++;
    took_input = 1'b0;
    if (cycles > CYCLE_LIMIT) begin
      $display("Run stopped at the cycle limit of %0d with %0d results still expected",
               CYCLE_LIMIT, expq.size());
      $display("tests failed");
      $finish;
    end else if (rst_n_i && flush_i) begin
      expq.delete(); // Everything in flight is dropped
    end else if (rst_n_i) begin
      if (out_valid_o && out_ready_i) begin
        if (expq.size() == 0) begin
          errors++;
          $display("Output transfer at %0t arrived with no result expected", $time);
        end else begin
          item = expq.pop_front();
          check_value("result", result_o, item.result);
          check_value("status", 64'(status_o), 64'(item.status));
          check_value("tag", 64'(tag_o), 64'(item.tag));
          if (item.timed) check_value("latency", 64'(cycles - item.acc_cycle), 64'(PIPE_REGS));
        end
      end
      if (in_valid_i && in_ready_o) begin
        predict(operands_i[0], operands_i[1], op_i, fmt_i == fpslice_pkg::FP16,
                vectorial_op_i, simd_mask_i, res, st);
        item.result    = res;
        item.status    = st;
        item.tag       = tag_i;
        item.acc_cycle = cycles;
        item.timed     = timed_phase;
        expq.push_back(item);
        took_input = 1'b1;
      end
    end
  end

  initial begin
    seed           = 32'h94a4_a222;
    rst_n_i        = 1'b0;
    operands_i     = '0;
    op_i           = fpslice_pkg::MIN;
    fmt_i          = fpslice_pkg::FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_n_i = 1'b1;

    run_ops(FREE_OPS, 1'b0);
    drain();
    run_ops(STALL_OPS, 1'b1); // Random back-pressure
    drain();
    repeat (FLUSH_ROUNDS) begin
      run_ops(FLUSH_OPS, 1'b1);
      pulse_flush();
    end

    errors += DUT.i_properties.failures;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule
